// ==== source/hbus_pkg.sv ====
package hbus_pkg;

    // Bus and word widths
    localparam int DQ_WIDTH   = 8;
    localparam int WORD_WIDTH = 2 * DQ_WIDTH;

    // Timing in clk cycles
    localparam int TACC_CYCLES    = 7;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = 32;
    localparam int CA_BEATS       = 3;

    // Shared latency, timeout and reset counter
    localparam int CNT_WIDTH = $clog2(TIMEOUT_CYCLES + 1);

    // One-hot bit positions of the sequencer state
    localparam int NUM_STATES  = 7;
    localparam int ST_RESET    = 0;
    localparam int ST_IDLE     = 1;
    localparam int ST_COMMAND  = 2;
    localparam int ST_LATENCY  = 3;
    localparam int ST_READ     = 4;
    localparam int ST_WRITE    = 5;
    localparam int ST_ERROR    = 6;

    // Host handshake states
    localparam logic [1:0] HP_WAIT   = 2'd0;
    localparam logic [1:0] HP_ACTIVE = 2'd1;
    localparam logic [1:0] HP_ACKED  = 2'd2;

    typedef struct packed {
        logic        read;
        logic        reg_space;
        logic        linear;
        logic [28:0] addr_hi;
        logic [12:0] reserved;
        logic [2:0]  addr_lo;
    } ca_fields_t;

    // Command/address word, built by field and sent by beat
    typedef union packed {
        ca_fields_t                          ca_fields;
        logic [CA_BEATS-1:0][WORD_WIDTH-1:0] ca_beats;
    } ca_word_t;

    typedef struct packed {
        logic                  write;
        logic                  reg_space;
        logic [31:0]           addr;
        logic [WORD_WIDTH-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] rd_data;
        logic                  error;
    } host_rsp_t;

endpackage

// ==== source/hbus_ddr_io.sv ====
module hbus_ddr_io #(
    parameter int WIDTH = 8
) (
    input  logic               outclk_i,
    input  logic               inclk_i,
    input  logic               rst,
    input  logic [2*WIDTH-1:0] dat_i,
    output logic [2*WIDTH-1:0] dat_o,
    input  logic               oe_i,
    inout  wire  [WIDTH-1:0]   pad
);

    logic [WIDTH-1:0] lo_out_q;
    logic [WIDTH-1:0] pad_out;
    logic [WIDTH-1:0] hi_in_q;
    logic [WIDTH-1:0] lo_in_q;

    // Lower half is taken at the falling edge and held through the low phase
    always_ff @(negedge outclk_i or posedge rst) begin
        if (rst) begin
            lo_out_q <= '0;
        end else begin
            lo_out_q <= dat_i[WIDTH-1:0];
        end
    end

    // Upper half goes out while outclk is high
    assign pad_out = outclk_i ? dat_i[2*WIDTH-1:WIDTH] : lo_out_q;
    assign pad     = oe_i ? pad_out : 'z;

    // Rising edge capture lands in the upper half
    always_ff @(posedge inclk_i or posedge rst) begin
        if (rst) begin
            hi_in_q <= '0;
        end else begin
            hi_in_q <= pad;
        end
    end

    always_ff @(negedge inclk_i or posedge rst) begin
        if (rst) begin
            lo_in_q <= '0;
        end else begin
            lo_in_q <= pad;
        end
    end

    assign dat_o = {hi_in_q, lo_in_q};

endmodule

// ==== source/hbus_host_port.sv ====
module hbus_host_port (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_i,
    input  hbus_pkg::host_req_t             host_req_i,
    output logic                            ack_o,
    output hbus_pkg::host_rsp_t             host_rsp_o,
    output logic                            start_o,
    output hbus_pkg::host_req_t             cmd_o,
    input  logic                            done_i,
    input  logic [hbus_pkg::WORD_WIDTH-1:0] rd_data_i,
    input  logic                            err_i
);
    import hbus_pkg::*;

    logic [1:0] state_q;
    logic       start_q;
    host_req_t  cmd_q;
    host_rsp_t  rsp_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= HP_WAIT;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state_q)
                HP_WAIT: begin
                    if (req_i) begin
                        start_q <= 1'b1;
                        state_q <= HP_ACTIVE;
                    end
                end
                HP_ACTIVE: begin
                    if (done_i) begin
                        state_q <= HP_ACKED;
                    end
                end
                HP_ACKED: begin
                    // Ack stays up until the host lets go of req
                    if (!req_i) begin
                        state_q <= HP_WAIT;
                    end
                end
                default: begin
                    state_q <= HP_WAIT;
                end
            endcase
        end
    end

    // Request is held for the sequencer, response is held for the host
    always_ff @(posedge clk) begin
        if (state_q == HP_WAIT && req_i) begin
            cmd_q <= host_req_i;
        end
        if (state_q == HP_ACTIVE && done_i) begin
            rsp_q.rd_data <= rd_data_i;
            rsp_q.error   <= err_i;
        end
    end

    assign ack_o      = (state_q == HP_ACKED);
    assign host_rsp_o = rsp_q;
    assign start_o    = start_q;
    assign cmd_o      = cmd_q;

endmodule

// ==== source/hbus_sequencer.sv ====
module hbus_sequencer (
    input  logic                            clk,
    input  logic                            clk90,
    input  logic                            rst,
    input  logic                            start_i,
    input  hbus_pkg::host_req_t             cmd_i,
    output logic                            done_o,
    output logic [hbus_pkg::WORD_WIDTH-1:0] rd_data_o,
    output logic                            err_o,
    output logic                            busy_o,
    output logic [hbus_pkg::WORD_WIDTH-1:0] dq_wr_o,
    input  logic [hbus_pkg::WORD_WIDTH-1:0] dq_rd_i,
    output logic                            dq_oe_o,
    output logic [1:0]                      rwds_wr_o,
    input  logic [1:0]                      rwds_rd_i,
    output logic                            rwds_oe_o,
    output logic                            hbus_clk_o,
    output logic                            hbus_csn_o,
    output logic                            hbus_rstn_o
);
    import hbus_pkg::*;

    logic [NUM_STATES-1:0] state_q;
    logic [CNT_WIDTH-1:0]  count_q;
    logic                  write_q;
    logic                  done_q;
    logic                  busy_q;
    logic                  clk_en_q;
    logic                  clk_en90_q;
    logic                  active;
    ca_word_t              ca_q;
    logic [WORD_WIDTH-1:0] wdata_q;
    logic [WORD_WIDTH-1:0] rd_data_q;

    // Device is selected from the first command beat to the data cycle
    assign active = state_q[ST_COMMAND] | state_q[ST_LATENCY] |
                    state_q[ST_READ] | state_q[ST_WRITE];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= NUM_STATES'(1) << ST_RESET;
            count_q  <= CNT_WIDTH'(RESET_CYCLES);
            write_q  <= 1'b0;
            done_q   <= 1'b0;
            busy_q   <= 1'b0;
            clk_en_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            // Busy from the start pulse to the done pulse
            if (start_i) begin
                busy_q <= 1'b1;
            end else if (done_q) begin
                busy_q <= 1'b0;
            end
            case (1'b1)
                state_q[ST_RESET]: begin
                    if (count_q == '0) begin
                        state_q <= NUM_STATES'(1) << ST_IDLE;
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
                state_q[ST_IDLE]: begin
                    if (start_i) begin
                        write_q  <= cmd_i.write;
                        count_q  <= CNT_WIDTH'(CA_BEATS - 1);
                        clk_en_q <= 1'b1;
                        state_q  <= NUM_STATES'(1) << ST_COMMAND;
                    end
                end
                state_q[ST_COMMAND]: begin
                    if (count_q == '0) begin
                        // RWDS held high through the command asks for double latency
                        if (rwds_rd_i == 2'b11) begin
                            count_q <= CNT_WIDTH'(2 * TACC_CYCLES - 1);
                        end else begin
                            count_q <= CNT_WIDTH'(TACC_CYCLES - 1);
                        end
                        state_q <= NUM_STATES'(1) << ST_LATENCY;
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
                state_q[ST_LATENCY]: begin
                    if (count_q == '0) begin
                        if (write_q) begin
                            state_q <= NUM_STATES'(1) << ST_WRITE;
                        end else begin
                            count_q <= CNT_WIDTH'(TIMEOUT_CYCLES - 1);
                            state_q <= NUM_STATES'(1) << ST_READ;
                        end
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
                state_q[ST_READ]: begin
                    if (rwds_rd_i != 2'b00) begin
                        done_q   <= 1'b1;
                        clk_en_q <= 1'b0;
                        state_q  <= NUM_STATES'(1) << ST_IDLE;
                    end else if (count_q == '0) begin
                        // No strobe from the device
                        done_q   <= 1'b1;
                        clk_en_q <= 1'b0;
                        state_q  <= NUM_STATES'(1) << ST_ERROR;
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
                state_q[ST_WRITE]: begin
                    done_q   <= 1'b1;
                    clk_en_q <= 1'b0;
                    state_q  <= NUM_STATES'(1) << ST_IDLE;
                end
                state_q[ST_ERROR]: begin
                    // Requests are answered at once while the bus stays quiet
                    done_q <= start_i;
                end
                default: begin
                    count_q  <= CNT_WIDTH'(RESET_CYCLES);
                    clk_en_q <= 1'b0;
                    state_q  <= NUM_STATES'(1) << ST_RESET;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q[ST_IDLE] && start_i) begin
            ca_q.ca_fields.read      <= ~cmd_i.write;
            ca_q.ca_fields.reg_space <= cmd_i.reg_space;
            ca_q.ca_fields.linear    <= 1'b1;
            ca_q.ca_fields.addr_hi   <= cmd_i.addr[31:3];
            ca_q.ca_fields.reserved  <= '0;
            ca_q.ca_fields.addr_lo   <= cmd_i.addr[2:0];
            wdata_q                  <= cmd_i.wdata;
        end else if (state_q[ST_COMMAND]) begin
            // Next beat moves to the top
            ca_q.ca_beats <= {ca_q.ca_beats[CA_BEATS-2:0], WORD_WIDTH'(0)};
        end
        if (state_q[ST_READ] && rwds_rd_i != 2'b00) begin
            rd_data_q <= dq_rd_i;
        end
    end

    // Enable rises while clk90 is low, so clk90 sets the first edge
    always_ff @(posedge clk90 or posedge rst) begin
        if (rst) begin
            clk_en90_q <= 1'b0;
        end else begin
            clk_en90_q <= clk_en_q;
        end
    end

    // The clk enable ends the clock before clk90 rises again
    assign hbus_clk_o = clk90 & clk_en_q & clk_en90_q;

    assign dq_wr_o   = state_q[ST_WRITE] ? wdata_q : ca_q.ca_beats[CA_BEATS-1];
    assign dq_oe_o   = state_q[ST_COMMAND] | state_q[ST_WRITE];
    // Mask low on both bytes of the data cycle
    assign rwds_wr_o = 2'b00;
    assign rwds_oe_o = state_q[ST_WRITE];

    assign hbus_csn_o  = ~active;
    assign hbus_rstn_o = ~state_q[ST_RESET];
    assign busy_o      = busy_q;
    assign err_o       = state_q[ST_ERROR];
    assign done_o      = done_q;
    assign rd_data_o   = rd_data_q;

endmodule

// ==== source/hbus_controller.sv ====
module hbus_controller (
    input  logic                          clk,
    input  logic                          clk90,
    input  logic                          rst,
    input  logic                          req_i,
    input  hbus_pkg::host_req_t           host_req_i,
    output logic                          ack_o,
    output hbus_pkg::host_rsp_t           host_rsp_o,
    output logic                          busy_o,
    output logic                          error_o,
    output logic                          hbus_clk_o,
    output logic                          hbus_csn_o,
    output logic                          hbus_rstn_o,
    inout  wire  [hbus_pkg::DQ_WIDTH-1:0] hbus_dq,
    inout  wire                           hbus_rwds
);
    import hbus_pkg::*;

    logic                  start;
    host_req_t             cmd;
    logic                  done;
    logic [WORD_WIDTH-1:0] rd_data;
    logic [2*DQ_WIDTH-1:0] dq_wr;
    logic [2*DQ_WIDTH-1:0] dq_rd;
    logic                  dq_oe;
    logic [1:0]            rwds_wr;
    logic [1:0]            rwds_rd;
    logic                  rwds_oe;

    hbus_host_port u_host_port (
        .clk        (clk),
        .rst        (rst),
        .req_i      (req_i),
        .host_req_i (host_req_i),
        .ack_o      (ack_o),
        .host_rsp_o (host_rsp_o),
        .start_o    (start),
        .cmd_o      (cmd),
        .done_i     (done),
        .rd_data_i  (rd_data),
        .err_i      (error_o)
    );

    hbus_sequencer u_sequencer (
        .clk         (clk),
        .clk90       (clk90),
        .rst         (rst),
        .start_i     (start),
        .cmd_i       (cmd),
        .done_o      (done),
        .rd_data_o   (rd_data),
        .err_o       (error_o),
        .busy_o      (busy_o),
        .dq_wr_o     (dq_wr),
        .dq_rd_i     (dq_rd),
        .dq_oe_o     (dq_oe),
        .rwds_wr_o   (rwds_wr),
        .rwds_rd_i   (rwds_rd),
        .rwds_oe_o   (rwds_oe),
        .hbus_clk_o  (hbus_clk_o),
        .hbus_csn_o  (hbus_csn_o),
        .hbus_rstn_o (hbus_rstn_o)
    );

    // Read data is captured on the strobe from the device
    hbus_ddr_io #(
        .WIDTH (DQ_WIDTH)
    ) u_ddr_dq (
        .outclk_i (clk),
        .inclk_i  (hbus_rwds),
        .rst      (rst),
        .dat_i    (dq_wr),
        .dat_o    (dq_rd),
        .oe_i     (dq_oe),
        .pad      (hbus_dq)
    );

    hbus_ddr_io #(
        .WIDTH (1)
    ) u_ddr_rwds (
        .outclk_i (clk),
        .inclk_i  (clk),
        .rst      (rst),
        .dat_i    (rwds_wr),
        .dat_o    (rwds_rd),
        .oe_i     (rwds_oe),
        .pad      (hbus_rwds)
    );

endmodule

// ==== bench/hyperram_model.sv ====
module hyperram_model #(
    parameter logic [15:0] ID0_VALUE = 16'h0C81,
    parameter logic [31:0] DEAD_BASE = 32'h0000_1000
) (
    input  logic       hbus_clk_i,
    input  logic       csn_i,
    input  logic       rstn_i,
    inout  wire  [7:0] dq,
    inout  wire        rwds,
    output logic       protocol_error_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TACC = 7;

    logic [15:0] mem [0:255];
    logic [47:0] ca;
    logic [31:0] addr;
    logic [7:0]  dq_out;
    logic [7:0]  wr_hi;
    logic [15:0] rd_word;
    logic        dq_oe;
    logic        rwds_out;
    logic        rwds_oe;
    logic        in_txn;
    logic        early;
    logic        csn_q;
    logic        clk_q;
    logic        dead_read;
    int          edges;
    int          idx;
    int          data_edge;

    assign dq        = dq_oe ? dq_out : 'z;
    assign rwds      = rwds_oe ? rwds_out : 'z;
    assign addr      = {ca[44:16], ca[2:0]};
    assign dead_read = ca[47] && (addr >= DEAD_BASE);

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0]};
        end
        ca               = '0;
        dq_oe            = 1'b0;
        rwds_oe          = 1'b0;
        rwds_out         = 1'b0;
        in_txn           = 1'b0;
        csn_q            = 1'b1;
        clk_q            = 1'b0;
        protocol_error_o = 1'b0;
    end

    always @(csn_i or hbus_clk_i) begin
        if (csn_i !== csn_q) begin
            csn_q = csn_i;
            if (csn_i === 1'b0) begin
                in_txn    = 1'b1;
                early     = !rstn_i;
                edges     = 0;
                data_edge = -1;
                rwds_out  = 1'b0;
                rwds_oe   = 1'b1;
            end else if (in_txn) begin
                in_txn  = 1'b0;
                dq_oe   = 1'b0;
                rwds_oe = 1'b0;
                // Transaction must end right after the data edge
                if (early || (!dead_read && edges != data_edge + 1)) begin
                    protocol_error_o = 1'b1;
                end
            end
        end
        if (hbus_clk_i !== clk_q) begin
            clk_q = hbus_clk_i;
            if (csn_i === 1'b0 && hbus_clk_i) begin
                if (edges < 3) begin
                    ca[47-16*edges -: 8] = dq;
                end
                // Latency phase, RWDS low on reads and released on writes
                if (edges == 3) begin
                    rwds_out = 1'b0;
                    rwds_oe  = ca[47];
                end
                if (edges == data_edge && ca[47] && !dead_read) begin
                    rd_word = ca[46] ? ID0_VALUE : mem[addr[7:0]];
                    dq_out  = rd_word[15:8];
                    dq_oe   = 1'b1;
                    #10 rwds_out = 1'b1;
                end
                if (edges == data_edge && !ca[47]) begin
                    wr_hi = dq;
                end
                edges++;
            end else if (csn_i === 1'b0) begin
                idx = edges - 1;
                if (idx < 3) begin
                    ca[39-16*idx -: 8] = dq;
                end
                // Address bit 4 is known here and selects double latency
                if (idx == 1) begin
                    rwds_out  = ca[17];
                    data_edge = 3 + (ca[17] ? 2 * TACC : TACC);
                end
                if (idx == data_edge && ca[47] && !dead_read) begin
                    dq_out = rd_word[7:0];
                    #10 rwds_out = 1'b0;
                end
                if (idx == data_edge && !ca[47]) begin
                    mem[addr[7:0]] = {wr_hi, dq};
                end
            end
        end
    end

endmodule

// ==== bench/hbus_assertions.sv ====
module hbus_assertions (
    input logic                clk,
    input logic                rst,
    input logic                req_i,
    input logic                ack_o,
    input hbus_pkg::host_rsp_t host_rsp_o,
    input logic                busy_o,
    input logic                error_o,
    input logic                hbus_csn_o,
    input logic                hbus_rstn_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic seen_req_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seen_req_q <= 1'b0;
        end else if (req_i) begin
            seen_req_q <= 1'b1;
        end
    end

    reset_holds_device: assert property (@(posedge clk) rst |-> !hbus_rstn_o)
        else $error("Device reset released during controller reset");
    reset_after_release: assert property (@(posedge clk) $fell(rst) |-> !hbus_rstn_o)
        else $error("Device reset released too early");
    quiet_until_request: assert property (@(posedge clk) disable iff (rst)
        !seen_req_q |-> hbus_csn_o && !ack_o && !busy_o && !error_o)
        else $error("Outputs active before the first request");
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack_o) |-> req_i)
        else $error("Ack rose without a request");
    ack_after_release: assert property (@(posedge clk) disable iff (rst)
        $fell(ack_o) |-> !$past(req_i))
        else $error("Ack fell before the request was released");
    rsp_stable: assert property (@(posedge clk) disable iff (rst)
        ack_o && $past(ack_o) |-> $stable(host_rsp_o))
        else $error("Response changed while ack was high");
    csn_idle: assert property (@(posedge clk) disable iff (rst) !busy_o |-> hbus_csn_o)
        else $error("Chip select low while not busy");
    error_sticky: assert property (@(posedge clk) disable iff (rst) !$fell(error_o))
        else $error("Error flag cleared without reset");

endmodule

// ==== bench/tb_hbus.sv ====
module tb_hbus;
    timeunit 1ns;
    timeprecision 100ps;
    import hbus_pkg::*;

    localparam logic [15:0] ID0_VALUE  = 16'h0C81;
    localparam logic [31:0] DEAD_BASE  = 32'h0000_1000;
    localparam int          WAIT_LIMIT = 200;
    localparam int          NUM_PAIRS  = 8;

    logic        clk;
    logic        clk90;
    logic        rst;
    logic        req;
    host_req_t   host_req;
    logic        ack;
    host_rsp_t   host_rsp;
    logic        busy;
    logic        error;
    logic        hbus_clk;
    logic        hbus_csn;
    logic        hbus_rstn;
    wire  [7:0]  hbus_dq;
    wire         hbus_rwds;
    logic        model_err;
    logic        csn_after_err;
    logic [15:0] lfsr_q;
    logic [15:0] shadow [0:255];

    hbus_controller dut (
        .clk         (clk),
        .clk90       (clk90),
        .rst         (rst),
        .req_i       (req),
        .host_req_i  (host_req),
        .ack_o       (ack),
        .host_rsp_o  (host_rsp),
        .busy_o      (busy),
        .error_o     (error),
        .hbus_clk_o  (hbus_clk),
        .hbus_csn_o  (hbus_csn),
        .hbus_rstn_o (hbus_rstn),
        .hbus_dq     (hbus_dq),
        .hbus_rwds   (hbus_rwds)
    );

    hyperram_model #(
        .ID0_VALUE (ID0_VALUE),
        .DEAD_BASE (DEAD_BASE)
    ) u_ram (
        .hbus_clk_i       (hbus_clk),
        .csn_i            (hbus_csn),
        .rstn_i           (hbus_rstn),
        .dq               (hbus_dq),
        .rwds             (hbus_rwds),
        .protocol_error_o (model_err)
    );

    bind hbus_controller hbus_assertions u_assertions (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .ack_o       (ack_o),
        .host_rsp_o  (host_rsp_o),
        .busy_o      (busy_o),
        .error_o     (error_o),
        .hbus_csn_o  (hbus_csn_o),
        .hbus_rstn_o (hbus_rstn_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // clk90 trails clk by a quarter period
    initial clk90 = 1'b0;
    always @(clk) begin
        #25 clk90 = clk;
    end

    always @(negedge hbus_csn) begin
        if (error) begin
            csn_after_err = 1'b1;
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        if (exp !== act) begin
            fail_now($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    // One four-phase handshake with the host port
    task automatic transact(input logic wr, input logic rs, input logic [31:0] a,
                            input logic [15:0] d, output host_rsp_t rsp);
        int n;
        @(posedge clk);
        req      <= 1'b1;
        host_req <= '{write: wr, reg_space: rs, addr: a, wdata: d};
        n = 0;
        while (!ack) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_now("Timeout waiting for ack_o to rise");
        end
        rsp = host_rsp;
        @(posedge clk);
        req <= 1'b0;
        n = 0;
        while (ack) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_now("Timeout waiting for ack_o to fall");
        end
        if (model_err) fail_now("HyperRAM model saw a latency or reset violation");
    endtask

    initial begin
        host_rsp_t   rsp;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] addrs [NUM_PAIRS];
        int          n;
        lfsr_q        = 16'd14;
        rst           = 1'b1;
        req           = 1'b0;
        host_req      = '0;
        csn_after_err = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        n = 0;
        while (!hbus_rstn) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_now("Timeout waiting for the device reset to end");
        end

        // Bit 4 alternates so both latencies are used
        for (int i = 0; i < NUM_PAIRS; i++) begin
            draw_bits(8, a);
            draw_bits(16, d);
            a[4] = i[0];
            addrs[i] = a;
            transact(1'b1, 1'b0, a, d[15:0], rsp);
            shadow[a[7:0]] = d[15:0];
            transact(1'b0, 1'b0, a, 16'h0, rsp);
            check_value("readback", shadow[a[7:0]], rsp.rd_data);
            check_value("readback error", 16'h0, 16'(rsp.error));
        end
        for (int i = 0; i < NUM_PAIRS; i++) begin
            transact(1'b0, 1'b0, addrs[i], 16'h0, rsp);
            check_value("second pass", shadow[addrs[i][7:0]], rsp.rd_data);
        end

        transact(1'b0, 1'b1, 32'h0, 16'h0, rsp);
        check_value("register read", ID0_VALUE, rsp.rd_data);
        check_value("register error", 16'h0, 16'(rsp.error));

        // Dead region read ends in the sticky error state
        draw_bits(8, a);
        transact(1'b0, 1'b0, DEAD_BASE | a, 16'h0, rsp);
        check_value("timeout error", 16'h1, 16'(rsp.error));
        check_value("error_o after timeout", 16'h1, 16'(error));
        transact(1'b1, 1'b0, a, 16'h1234, rsp);
        check_value("error after timeout", 16'h1, 16'(rsp.error));
        if (csn_after_err) fail_now("Chip select went low in the error state");

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== tb.f ====
source/hbus_pkg.sv
source/hbus_ddr_io.sv
source/hbus_host_port.sv
source/hbus_sequencer.sv
source/hbus_controller.sv
bench/hyperram_model.sv
bench/hbus_assertions.sv
bench/tb_hbus.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_hbus
FILELIST = tb.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf $(OBJDIR)
